/* verilog/ucpd_bmc_macros.svh */
`ifndef UCPD_BMC_MACROS_SVH
`define UCPD_BMC_MACROS_SVH

// --------------------
// cycle count widths
// --------------------

// run lengths, edge intervals and the short/long threshold
`define UCPD_UI_W 11

// sum of three preamble runs, room for 3 x 2047
`define UCPD_UI_SUM_W 13

// --------------------
// training constants
// --------------------

// threshold = (a + b + c) * 3 / 8
// a+b+c spans two UI, so this is 3/4 of one UI
`define UCPD_TH_MUL 3
`define UCPD_TH_SHIFT 3

// run index of the third captured run
`define UCPD_RUN_LAST 2'd2

`endif

/* verilog/ucpd_cc_pkg.sv */
package ucpd_cc_pkg;

  // --------------------
  // rx glitch filter mode
  // --------------------

  // bit 1 picks the 2-sample window, bit 0 bypasses the filter
  typedef enum logic [1:0] {
    FILT_THREE  = 2'b00,
    FILT_BYPASS = 2'b01,
    FILT_TWO    = 2'b10
  } filt_mode_e;

  // --------------------
  // filtered cc line
  // --------------------

  // level after the filter, plus one-cycle pulse on every change
  typedef struct packed {
    logic level;
    logic edge_pulse;
  } cc_line_t;

  // tx timing strobes, one cycle wide
  // half_tick fires at bit start and at mid-bit
  typedef struct packed {
    logic bit_tick;
    logic half_tick;
  } tx_strobe_t;

endpackage

/* verilog/ucpd_rx_pkg.sv */
`include "ucpd_bmc_macros.svh"

package ucpd_rx_pkg;

  // --------------------
  // preamble training
  // --------------------

  // threshold is 3/4 UI in ucpd_clk cycles
  // only meaningful while trained is high
  typedef struct packed {
    logic                  trained;
    logic [`UCPD_UI_W-1:0] threshold;
  } ui_train_t;

  // --------------------
  // edge spacing
  // --------------------

  // cycles between two filtered edges, saturating
  typedef struct packed {
    logic                  valid;
    logic [`UCPD_UI_W-1:0] count;
  } edge_interval_t;

  // --------------------
  // decoded bits
  // --------------------

  // one pulse per bit, no back-pressure
  typedef struct packed {
    logic valid;
    logic value;
  } rx_bit_t;

endpackage

/* verilog/ucpd_cc_filter.sv */
`timescale 1ns/1ns

module ucpd_cc_filter (
  input  logic                    ucpd_clk,
  input  logic                    ic_rst_n,
  input  logic                    ucpden,
  input  logic                    cc_in,
  input  ucpd_cc_pkg::filt_mode_e mode,
  output ucpd_cc_pkg::cc_line_t   line
);

  // two-flop synchronizer
  logic sync_meta;
  logic sync_q;
  // older samples of the synchronized bit
  logic samp_d0;
  logic samp_d1;
  // window agreement
  logic all_hi;
  logic all_lo;
  // filtered level and its delayed copy
  logic level_q;
  logic level_d;

  // --------------------
  // sync and sample chain
  // --------------------
  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      sync_meta <= 1'b0;
      sync_q    <= 1'b0;
      samp_d0   <= 1'b0;
      samp_d1   <= 1'b0;
    end else begin
      // line reads as idle low while the block is off
      sync_meta <= cc_in & ucpden;
      sync_q    <= sync_meta;
      samp_d0   <= sync_q;
      samp_d1   <= samp_d0;
    end
  end

  // --------------------
  // glitch window
  // --------------------
  // new level only once every sample in the window agrees,
  // so rising and falling edges see the same delay
  always_comb begin
    case (mode)
      ucpd_cc_pkg::FILT_BYPASS: begin
        all_hi = sync_q;
        all_lo = ~sync_q;
      end
      ucpd_cc_pkg::FILT_TWO: begin
        all_hi = sync_q & samp_d0;
        all_lo = ~(sync_q | samp_d0);
      end
      default: begin
        all_hi = sync_q & samp_d0 & samp_d1;
        all_lo = ~(sync_q | samp_d0 | samp_d1);
      end
    endcase
  end

  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      level_q <= 1'b0;
      level_d <= 1'b0;
    end else begin
      // mixed window holds the old level
      if (all_hi) begin
        level_q <= 1'b1;
      end else if (all_lo) begin
        level_q <= 1'b0;
      end
      level_d <= level_q;
    end
  end

  // edge pulse for one cycle after each level change
  assign line.level      = level_q;
  assign line.edge_pulse = level_q ^ level_d;

endmodule

/* verilog/ucpd_bmc_encoder.sv */
`timescale 1ns/1ns

module ucpd_bmc_encoder (
  input  logic                    ucpd_clk,
  input  logic                    ic_rst_n,
  input  logic                    ucpden,
  input  logic                    bmc_en,
  input  logic                    tx_bit,
  input  ucpd_cc_pkg::tx_strobe_t strobe,
  output logic                    cc_out
);

  // --------------------
  // BMC rules
  // --------------------
  // every bit starts with a transition
  // a one adds a second transition at mid-bit
  // a zero holds its level for the whole bit
  //
  // half_tick covers both start and mid-bit, so a one
  // toggles on it; a zero toggles only on bit_tick

  logic tx_level;
  logic toggle;

  // strobe that applies to the current bit value
  assign toggle = tx_bit ? strobe.half_tick : strobe.bit_tick;

  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      tx_level <= 1'b0;
    end else if (!bmc_en) begin
      // idle low between frames
      tx_level <= 1'b0;
    end else if (toggle) begin
      tx_level <= ~tx_level;
    end
  end

  // driver off when the block is disabled
  assign cc_out = tx_level & ucpden;

endmodule

/* verilog/ucpd_ui_trainer.sv */
`timescale 1ns/1ns

`include "ucpd_bmc_macros.svh"

module ucpd_ui_trainer (
  input  logic                    ucpd_clk,
  input  logic                    ic_rst_n,
  input  logic                    rx_en,
  input  logic                    receive_en,
  input  ucpd_cc_pkg::cc_line_t   line,
  output ucpd_rx_pkg::ui_train_t  train
);

  // product of the run sum and the multiplier
  localparam int PROD_W = `UCPD_UI_SUM_W + 2;

  localparam logic [`UCPD_UI_W-1:0] RUN_ONE  = 1;
  localparam logic [`UCPD_UI_W-1:0] RUN_MAX  = '1;
  localparam logic [PROD_W-1:0]     TH_MUL_W = `UCPD_TH_MUL;

  // control
  logic       recv_d;
  logic       restart;
  logic       learn_en;
  logic       active;
  logic       trained_q;
  logic       run_close;
  logic [1:0] run_idx;

  // run lengths, a and b captured, c is the run closing now
  logic [`UCPD_UI_W-1:0] run_cnt;
  logic [`UCPD_UI_W-1:0] run_a;
  logic [`UCPD_UI_W-1:0] run_b;

  // threshold math
  logic                      accept;
  logic [`UCPD_UI_SUM_W-1:0] run_sum;
  logic [PROD_W-1:0]         th_prod;
  logic [PROD_W-1:0]         th_wide;
  logic [`UCPD_UI_W-1:0]     th_sat;
  logic [`UCPD_UI_W-1:0]     th_q;

  // --------------------
  // enables
  // --------------------
  // start over when rx is off or a frame just ended
  assign restart  = ~rx_en | (recv_d & ~receive_en);
  // learn only between frames and until trained
  assign learn_en = rx_en & ~receive_en & ~trained_q;
  // an edge that ends a counted run
  assign run_close = learn_en & line.edge_pulse & active;

  // --------------------
  // threshold
  // --------------------
  assign run_sum = {2'b00, run_a} + {2'b00, run_b} + {2'b00, run_cnt};
  assign th_prod = {2'b00, run_sum} * TH_MUL_W;
  assign th_wide = th_prod >> `UCPD_TH_SHIFT;
  // clamp to the count width
  assign th_sat  = (|th_wide[PROD_W-1:`UCPD_UI_W]) ? RUN_MAX : th_wide[`UCPD_UI_W-1:0];

  // preamble starts 0,1: one long run then two short ones
  // c largest means the leading 0 was missed; b largest means a lost 1,
  // so anything but a or c on top is thrown away
  assign accept = ((run_cnt > run_a) && (run_cnt > run_b)) ||
                  ((run_a > run_b) && (run_a > run_cnt));

  // --------------------
  // run counter and state
  // --------------------
  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      recv_d    <= 1'b0;
      active    <= 1'b0;
      run_idx   <= 2'd0;
      run_cnt   <= '0;
      trained_q <= 1'b0;
      th_q      <= '0;
    end else begin
      recv_d <= receive_en;
      if (restart) begin
        active    <= 1'b0;
        run_idx   <= 2'd0;
        run_cnt   <= '0;
        trained_q <= 1'b0;
      end else if (learn_en) begin
        if (line.edge_pulse) begin
          // first edge only opens the first run
          active  <= 1'b1;
          run_cnt <= RUN_ONE;
          if (active) begin
            if (run_idx == `UCPD_RUN_LAST) begin
              // a rejected set restarts capture at the next edge
              run_idx   <= 2'd0;
              trained_q <= accept;
              th_q      <= th_sat;
            end else begin
              run_idx <= run_idx + 2'd1;
            end
          end
        end else if (active && (run_cnt != RUN_MAX)) begin
          run_cnt <= run_cnt + RUN_ONE;
        end
      end
    end
  end

  // first two runs
  always_ff @(posedge ucpd_clk) begin
    if (run_close) begin
      if (run_idx == 2'd0) begin
        run_a <= run_cnt;
      end else if (run_idx == 2'd1) begin
        run_b <= run_cnt;
      end
    end
  end

  assign train.trained   = trained_q;
  assign train.threshold = th_q;

endmodule

/* verilog/ucpd_edge_timer.sv */
`timescale 1ns/1ns

`include "ucpd_bmc_macros.svh"

module ucpd_edge_timer (
  input  logic                        ucpd_clk,
  input  logic                        ic_rst_n,
  input  ucpd_cc_pkg::cc_line_t       line,
  output ucpd_rx_pkg::edge_interval_t interval
);

  localparam logic [`UCPD_UI_W-1:0] CNT_ONE = 1;
  localparam logic [`UCPD_UI_W-1:0] CNT_MAX = '1;

  logic [`UCPD_UI_W-1:0] run_cnt;
  logic [`UCPD_UI_W-1:0] count_q;
  logic                  valid_q;

  // --------------------
  // edge-to-edge counter
  // --------------------
  // holds k during the k-th cycle after an edge,
  // so at the next edge it equals the spacing
  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      run_cnt <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= line.edge_pulse;
      if (line.edge_pulse) begin
        run_cnt <= CNT_ONE;
      end else if (run_cnt != CNT_MAX) begin
        // long idle parks at max
        run_cnt <= run_cnt + CNT_ONE;
      end
    end
  end

  // spacing latched with the edge
  always_ff @(posedge ucpd_clk) begin
    if (line.edge_pulse) begin
      count_q <= run_cnt;
    end
  end

  assign interval.valid = valid_q;
  assign interval.count = count_q;

endmodule

/* verilog/ucpd_bit_slicer.sv */
`timescale 1ns/1ns

module ucpd_bit_slicer (
  input  logic                        ucpd_clk,
  input  logic                        ic_rst_n,
  input  logic                        rx_en,
  input  logic                        eop_ok,
  input  ucpd_rx_pkg::ui_train_t      train,
  input  ucpd_rx_pkg::edge_interval_t interval,
  output ucpd_rx_pkg::rx_bit_t        rx_bit,
  output logic                        receive_en
);

  logic trained_d;
  logic train_rise;
  logic is_long;
  logic slice_en;
  // first short half of a one seen
  logic half_pend;
  logic bit_valid_q;
  logic bit_value_q;

  assign train_rise = train.trained & ~trained_d;
  // above 3/4 UI is a full zero, below is half of a one
  assign is_long    = interval.count > train.threshold;
  assign slice_en   = receive_en & ~eop_ok;

  // --------------------
  // receive window
  // --------------------
  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      trained_d  <= 1'b0;
      receive_en <= 1'b0;
    end else begin
      trained_d <= train.trained;
      // end of packet wins over a new training result
      if (!rx_en || eop_ok) begin
        receive_en <= 1'b0;
      end else if (train_rise) begin
        receive_en <= 1'b1;
      end
    end
  end

  // --------------------
  // short/long slicing
  // --------------------
  // receive_en is still low when trained rises, so the interval
  // of the edge that closed training never gets sliced
  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      half_pend   <= 1'b0;
      bit_valid_q <= 1'b0;
      bit_value_q <= 1'b0;
    end else begin
      bit_valid_q <= 1'b0;
      if (!slice_en) begin
        half_pend <= 1'b0;
      end else if (interval.valid) begin
        if (is_long) begin
          bit_valid_q <= 1'b1;
          bit_value_q <= 1'b0;
          half_pend   <= 1'b0;
        end else if (half_pend) begin
          // second short half closes a one
          bit_valid_q <= 1'b1;
          bit_value_q <= 1'b1;
          half_pend   <= 1'b0;
        end else begin
          half_pend <= 1'b1;
        end
      end
    end
  end

  assign rx_bit.valid = bit_valid_q;
  assign rx_bit.value = bit_value_q;

endmodule

/* verilog/ucpd_bmc_phy.sv */
`timescale 1ns/1ns

module ucpd_bmc_phy (
  input  logic                    ucpd_clk,
  input  logic                    ic_rst_n,
  input  logic                    ucpden,
  input  logic                    ic_cc_in,
  input  ucpd_cc_pkg::filt_mode_e rxfilte,
  input  logic                    rx_en,
  input  logic                    eop_ok,
  input  logic                    bmc_en,
  input  logic                    tx_bit,
  input  ucpd_cc_pkg::tx_strobe_t tx_strobe,
  output logic                    ic_cc_out,
  output ucpd_rx_pkg::rx_bit_t    rx_bit,
  output logic                    receive_en
);

  // filtered line, shared by trainer and timer
  ucpd_cc_pkg::cc_line_t       cc_line;
  ucpd_rx_pkg::ui_train_t      train;
  ucpd_rx_pkg::edge_interval_t interval;

  // --------------------
  // receive path
  // --------------------
  ucpd_cc_filter ucpd_cc_filter_inst (
    .ucpd_clk (ucpd_clk),
    .ic_rst_n (ic_rst_n),
    .ucpden   (ucpden),
    .cc_in    (ic_cc_in),
    .mode     (rxfilte),
    .line     (cc_line)
  );

  // learns the threshold, frozen for the frame
  ucpd_ui_trainer ucpd_ui_trainer_inst (
    .ucpd_clk   (ucpd_clk),
    .ic_rst_n   (ic_rst_n),
    .rx_en      (rx_en),
    .receive_en (receive_en),
    .line       (cc_line),
    .train      (train)
  );

  // runs alongside the trainer on every edge
  ucpd_edge_timer ucpd_edge_timer_inst (
    .ucpd_clk (ucpd_clk),
    .ic_rst_n (ic_rst_n),
    .line     (cc_line),
    .interval (interval)
  );

  ucpd_bit_slicer ucpd_bit_slicer_inst (
    .ucpd_clk   (ucpd_clk),
    .ic_rst_n   (ic_rst_n),
    .rx_en      (rx_en),
    .eop_ok     (eop_ok),
    .train      (train),
    .interval   (interval),
    .rx_bit     (rx_bit),
    .receive_en (receive_en)
  );

  // --------------------
  // transmit path
  // --------------------
  ucpd_bmc_encoder ucpd_bmc_encoder_inst (
    .ucpd_clk (ucpd_clk),
    .ic_rst_n (ic_rst_n),
    .ucpden   (ucpden),
    .bmc_en   (bmc_en),
    .tx_bit   (tx_bit),
    .strobe   (tx_strobe),
    .cc_out   (ic_cc_out)
  );

endmodule

/* dv/ucpd_bmc_phy_tb_table.svh */
`ifndef UCPD_BMC_PHY_TB_TABLE_SVH
`define UCPD_BMC_PHY_TB_TABLE_SVH

// --------------------
// stimulus rows
// --------------------

// one frame on the loopback wire
// pattern bit 0 goes out first, bits 0 and 1 are always 0, 1
typedef struct packed {
  ucpd_cc_pkg::filt_mode_e mode;
  logic [31:0]             pattern;
  logic [5:0]              len;
  logic [4:0]              half;
  logic                    glitch;
  // bit index where eop_ok pulses, 0 for none
  logic [5:0]              eop_at;
  // fill bits 2 and up from $urandom
  logic                    rnd;
  // ucpden for the whole row
  logic                    en;
} stim_row_t;

stim_row_t rows[$];

task automatic add_row(input ucpd_cc_pkg::filt_mode_e mode, input logic [31:0] pattern,
                       input int len, input int half, input logic glitch,
                       input int eop_at, input logic rnd, input logic en);
  stim_row_t row;
  row.mode    = mode;
  row.pattern = pattern;
  row.len     = len[5:0];
  row.half    = half[4:0];
  row.glitch  = glitch;
  row.eop_at  = eop_at[5:0];
  row.rnd     = rnd;
  row.en      = en;
  rows.push_back(row);
endtask

// columns: mode, pattern, length, half-bit cycles, glitch, eop bit, random, ucpden
task automatic load_table();
  // plain loopback in every filter mode
  add_row(ucpd_cc_pkg::FILT_BYPASS, 32'h0000_B4D6, 16, 8,  0, 0, 0, 1);
  add_row(ucpd_cc_pkg::FILT_TWO,    32'h0000_9C2A, 16, 10, 0, 0, 0, 1);
  add_row(ucpd_cc_pkg::FILT_THREE,  32'h00A5_3C6E, 24, 8,  0, 0, 0, 1);
  add_row(ucpd_cc_pkg::FILT_BYPASS, 32'h5A5A_F00A, 32, 10, 0, 0, 0, 1);
  // one-cycle pulse inside the first long bit
  add_row(ucpd_cc_pkg::FILT_TWO,    32'h0000_0F02, 12, 8,  1, 0, 0, 1);
  add_row(ucpd_cc_pkg::FILT_THREE,  32'h0000_3362, 16, 10, 1, 0, 0, 1);
  // random payload after the preamble
  add_row(ucpd_cc_pkg::FILT_TWO,    32'h0000_0002, 28, 8,  0, 0, 1, 1);
  add_row(ucpd_cc_pkg::FILT_THREE,  32'h0000_0002, 32, 10, 0, 0, 1, 1);
  add_row(ucpd_cc_pkg::FILT_BYPASS, 32'h0000_0002, 20, 10, 0, 0, 1, 1);
  // end of packet at bit 12, all ones from bit 11 so no retrain
  add_row(ucpd_cc_pkg::FILT_TWO,    32'h000F_FA96, 20, 8,  0, 12, 0, 1);
  // block off, then back on
  add_row(ucpd_cc_pkg::FILT_BYPASS, 32'h0000_B4D6, 16, 8,  0, 0, 0, 0);
  add_row(ucpd_cc_pkg::FILT_THREE,  32'h0000_6E96, 16, 10, 0, 0, 0, 1);
endtask

`endif

/* dv/ucpd_bmc_phy_tb.sv */
`timescale 1ns/1ns

module ucpd_bmc_phy_tb;

  logic                    ucpd_clk;
  logic                    ic_rst_n;
  logic                    ucpden;
  logic                    ic_cc_in;
  ucpd_cc_pkg::filt_mode_e rxfilte;
  logic                    rx_en;
  logic                    eop_ok;
  logic                    bmc_en;
  logic                    tx_bit;
  ucpd_cc_pkg::tx_strobe_t tx_strobe;
  logic                    ic_cc_out;
  ucpd_rx_pkg::rx_bit_t    rx_bit;
  logic                    receive_en;

  // one-cycle flip on the loopback wire
  logic glitch_q;
  // monitor state
  logic tx_window;
  logic post_eop;
  logic last_cc_out;
  logic table_ready;
  int   toggle_cnt;
  int   errors;
  logic got_bits[$];
  logic exp_bits[$];

  `include "ucpd_bmc_phy_tb_table.svh"

  // tx looped back to rx
  assign ic_cc_in = ic_cc_out ^ glitch_q;

  ucpd_bmc_phy ucpd_bmc_phy_inst (
    .ucpd_clk   (ucpd_clk),
    .ic_rst_n   (ic_rst_n),
    .ucpden     (ucpden),
    .ic_cc_in   (ic_cc_in),
    .rxfilte    (rxfilte),
    .rx_en      (rx_en),
    .eop_ok     (eop_ok),
    .bmc_en     (bmc_en),
    .tx_bit     (tx_bit),
    .tx_strobe  (tx_strobe),
    .ic_cc_out  (ic_cc_out),
    .rx_bit     (rx_bit),
    .receive_en (receive_en)
  );

  always #2 ucpd_clk = ~ucpd_clk;

  task automatic expect_int(input string name, input int got, input int exp);
    assert (got == exp) else begin
      $display("ERROR %0t: %s = %0d, expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  // --------------------
  // monitor
  // --------------------
  // outputs settle after posedge, read them at negedge
  always @(negedge ucpd_clk) begin
    if (ic_rst_n === 1'b1) begin
      if (tx_window && (ic_cc_out !== last_cc_out)) begin
        toggle_cnt++;
      end
      last_cc_out = ic_cc_out;
      if (!ucpden) begin
        expect_int("ic_cc_out", ic_cc_out, 0);
      end
      if (rx_bit.valid) begin
        got_bits.push_back(rx_bit.value);
        expect_int("receive_en", receive_en, 1);
        assert (!post_eop) else begin
          $display("rx_bit.valid pulsed after eop_ok at %0t", $time);
          errors++;
        end
      end
    end
  end

  // one bit slot, strobes at start and mid-bit
  task automatic drive_bit(input logic value, input int half, input int glitch_cyc,
                           input logic eop_now);
    int j;
    for (j = 0; j < 2 * half; j++) begin
      @(posedge ucpd_clk);
      #1;
      tx_bit              = value;
      tx_strobe.bit_tick  = (j == 0);
      tx_strobe.half_tick = (j == 0) || (j == half);
      glitch_q            = (j == glitch_cyc);
      eop_ok              = eop_now && (j == 0);
      if (eop_now && (j == 0)) begin
        post_eop = 1'b1;
      end
      if (eop_now && (j == 2)) begin
        expect_int("receive_en", receive_en, 0);
      end
    end
  endtask

  // --------------------
  // watchdog
  // --------------------
  initial begin : watchdog
    int limit;
    wait (table_ready);
    limit = 100;
    foreach (rows[r]) begin
      limit += (int'(rows[r].len) + 4) * 2 * int'(rows[r].half) + 50;
    end
    repeat (limit) @(posedge ucpd_clk);
    $display("timeout, run still going after %0d cycles", limit);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin : main
    stim_row_t   row;
    logic [31:0] pat;
    logic [31:0] rnd_word;
    int          last_bit;
    int          glitch_bit;
    int          exp_toggles;
    int          err_before;
    int          rows_failed;
    int          i;

    ucpd_clk    = 1'b0;
    ic_rst_n    = 1'b0;
    ucpden      = 1'b0;
    rxfilte     = ucpd_cc_pkg::FILT_BYPASS;
    rx_en       = 1'b0;
    eop_ok      = 1'b0;
    bmc_en      = 1'b0;
    tx_bit      = 1'b0;
    tx_strobe   = '0;
    glitch_q    = 1'b0;
    tx_window   = 1'b0;
    post_eop    = 1'b0;
    last_cc_out = 1'b0;
    toggle_cnt  = 0;
    errors      = 0;
    rows_failed = 0;
    rnd_word    = $urandom(32'h9219_1e1b);
    load_table();
    table_ready = 1'b1;

    repeat (5) @(posedge ucpd_clk);
    #1;
    ic_rst_n = 1'b1;
    @(negedge ucpd_clk);
    expect_int("ic_cc_out", ic_cc_out, 0);
    expect_int("receive_en", receive_en, 0);
    expect_int("rx_bit.valid", rx_bit.valid, 0);

    foreach (rows[r]) begin
      row        = rows[r];
      err_before = errors;
      pat        = row.pattern;
      if (row.rnd) begin
        rnd_word  = $urandom();
        pat[31:2] = rnd_word[31:2];
      end
      // training eats bits 0 and 1, eop cuts the tail
      last_bit    = (row.eop_at != 0) ? int'(row.eop_at) - 2 : int'(row.len) - 1;
      exp_toggles = row.en ? int'(row.len) + 1 : 0;
      glitch_bit  = -1;
      exp_bits.delete();
      for (i = 0; i < row.len; i++) begin
        if (row.en && pat[i]) begin
          exp_toggles++;
        end
        if (row.en && (i >= 2) && (i <= last_bit)) begin
          exp_bits.push_back(pat[i]);
        end
        if (row.glitch && (glitch_bit < 0) && (i >= 2) && !pat[i]) begin
          glitch_bit = i;
        end
      end

      @(posedge ucpd_clk);
      #1;
      ucpden     = row.en;
      rxfilte    = row.mode;
      rx_en      = 1'b1;
      bmc_en     = 1'b1;
      post_eop   = 1'b0;
      toggle_cnt = 0;
      got_bits.delete();
      tx_window  = 1'b1;
      for (i = 0; i < row.len; i++) begin
        drive_bit(pat[i], row.half, (i == glitch_bit) ? int'(row.half) : -1,
                  (row.eop_at != 0) && (i == row.eop_at));
      end
      // extra zero slot gives the last bit its closing edge
      drive_bit(1'b0, row.half, -1, 1'b0);
      for (i = 0; (i < 4 * row.half) && (got_bits.size() < exp_bits.size()); i++) begin
        @(posedge ucpd_clk);
      end
      @(posedge ucpd_clk);
      #1;
      tx_window = 1'b0;
      rx_en     = 1'b0;
      bmc_en    = 1'b0;
      // let the filter drain before the next row
      repeat (12) @(posedge ucpd_clk);
      #1;

      expect_int("rx bit count", got_bits.size(), exp_bits.size());
      foreach (exp_bits[k]) begin
        if (k < got_bits.size()) begin
          expect_int($sformatf("rx_bit.value[%0d]", k), got_bits[k], exp_bits[k]);
        end
      end
      expect_int("ic_cc_out toggles", toggle_cnt, exp_toggles);
      expect_int("receive_en", receive_en, 0);
      if (errors != err_before) begin
        rows_failed++;
      end
      $display("row %0d: mode %0d, %0d bits, %0d decoded, %s", r, row.mode, row.len,
               got_bits.size(), (errors == err_before) ? "pass" : "fail");
    end

    $display("%0d rows, %0d passed, %0d failed, %0d errors", rows.size(),
             rows.size() - rows_failed, rows_failed, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* compile.f */
+incdir+verilog
+incdir+dv
verilog/ucpd_cc_pkg.sv
verilog/ucpd_rx_pkg.sv
verilog/ucpd_cc_filter.sv
verilog/ucpd_bmc_encoder.sv
verilog/ucpd_ui_trainer.sv
verilog/ucpd_edge_timer.sv
verilog/ucpd_bit_slicer.sv
verilog/ucpd_bmc_phy.sv
dv/ucpd_bmc_phy_tb.sv

/* Bender.yml */
package:
  name: ucpd_bmc_phy

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/ucpd_cc_pkg.sv
      - verilog/ucpd_rx_pkg.sv
      - verilog/ucpd_cc_filter.sv
      - verilog/ucpd_bmc_encoder.sv
      - verilog/ucpd_ui_trainer.sv
      - verilog/ucpd_edge_timer.sv
      - verilog/ucpd_bit_slicer.sv
      - verilog/ucpd_bmc_phy.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/ucpd_bmc_phy_tb.sv
